// File: icmp_tx.f
verilog/icmp_pkg.sv
verilog/icmp_checksum.sv
verilog/icmp_header_build.sv
verilog/icmp_crc32.sv
verilog/icmp_tx_fsm.sv
verilog/icmp_tx.sv
dv/icmp_tx_assertions.sv
dv/icmp_tx_tb.sv

// File: Makefile
TOP = icmp_tx_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f icmp_tx.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: dv/icmp_tx_tb.sv
// icmp transmitter testbench
`timescale 1ns/1ps

module icmp_tx_tb;

    localparam logic [7:0] TTL = 8'h80;
    // ------------------------------------------------------------------
    // run length: seven frames, 526 bytes, plus gaps and settle time
    // ------------------------------------------------------------------
    localparam int TOTAL_BYTES     = 526;
    localparam int N_FRAMES        = 7;
    localparam int WATCHDOG_CYCLES = 4 * (TOTAL_BYTES + N_FRAMES * 20) + 400;
    localparam int FRAME_TIMEOUT   = 1000;

    logic                clk;
    logic                rst_n;
    logic                start_txen;
    icmp_pkg::addr_cfg_t addr;
    logic [15:0]         icmp_id;
    logic [15:0]         icmp_seq;
    icmp_pkg::len_t      payload_len;
    logic [31:0]         reply_checksum;
    logic [7:0]          tx_data;
    logic                data_req;
    logic                txvld;
    logic [7:0]          txdata;
    logic                tx_done;

    logic [7:0] payload[$];
    logic [7:0] frame_q[$];
    logic [7:0] exp_q[$];
    int         req_count;
    int         done_count;
    int         pay_idx;
    bit         req_pend;
    int         errors;
    int         checks;
    logic [15:0] exp_ident;

    icmp_tx #(
        .TTL (TTL)
    ) u_icmp_tx (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_start_txen     (start_txen),
        .i_addr           (addr),
        .i_icmp_id        (icmp_id),
        .i_icmp_seq       (icmp_seq),
        .i_payload_len    (payload_len),
        .i_reply_checksum (reply_checksum),
        .i_tx_data        (tx_data),
        .o_data_req       (data_req),
        .o_txvld          (txvld),
        .o_txdata         (txdata),
        .o_tx_done        (tx_done)
    );

    bind icmp_tx icmp_tx_assertions u_assertions (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .o_data_req (o_data_req),
        .o_txvld    (o_txvld),
        .o_tx_done  (o_tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // payload source, byte follows the request by one cycle
    always @(negedge clk) begin
        if (req_pend) begin
            if (pay_idx < payload.size()) begin
                tx_data = payload[pay_idx];
            end
            pay_idx = pay_idx + 1;
        end
        req_pend = data_req;
    end

    always @(negedge clk) begin
        if (txvld) begin
            frame_q.push_back(txdata);
        end
        if (data_req) req_count++;
        if (tx_done) done_count++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic logic [15:0] fold(input logic [31:0] s);
        while (s[31:16] != 16'h0) begin
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        end
        return s[15:0];
    endfunction

    function automatic logic [31:0] payload_sum();
        logic [31:0] s;
        s = 32'h0;
        for (int i = 0; i < payload.size(); i += 2) begin
            if (i + 1 < payload.size()) s += {16'h0, payload[i], payload[i+1]};
            else s += {16'h0, payload[i], 8'h00};   // odd tail
        end
        return s;
    endfunction

    function automatic logic [15:0] ip_checksum(input logic [15:0] total_len,
                                                input logic [15:0] ident);
        logic [31:0] s;
        s = 32'h4500 + total_len + ident + 32'h4000 + {16'h0, TTL, 8'h01};
        s += addr.src_ip[31:16] + addr.src_ip[15:0];
        s += addr.dst_ip[31:16] + addr.dst_ip[15:0];
        return ~fold(s);
    endfunction

    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] d);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[0] ^ d[i];
            crc = crc >> 1;
            if (fb) crc = crc ^ 32'hedb8_8320;
        end
        return crc;
    endfunction

    function automatic void push_bytes(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back(v[8*i +: 8]);
        end
    endfunction

    function automatic void build_expected(input logic [15:0] ident);
        int          len;
        int          padded;
        logic [15:0] total_len;
        logic [31:0] crc;
        len       = payload.size();
        padded    = (len > 18) ? len : 18;
        total_len = 16'(len + 28);
        exp_q.delete();
        for (int i = 0; i < 7; i++) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        push_bytes(addr.dst_mac, 6);
        push_bytes(addr.src_mac, 6);
        push_bytes(48'h0800, 2);
        // ip header
        push_bytes({32'h0, 16'h4500}, 2);
        push_bytes({32'h0, total_len}, 2);
        push_bytes({32'h0, ident}, 2);
        push_bytes({32'h0, 16'h4000}, 2);
        push_bytes({32'h0, TTL, 8'h01}, 2);
        push_bytes({32'h0, ip_checksum(total_len, ident)}, 2);
        push_bytes({16'h0, addr.src_ip}, 4);
        push_bytes({16'h0, addr.dst_ip}, 4);
        // icmp header, type and code zero
        push_bytes(48'h0, 2);
        push_bytes({32'h0, ~fold(32'(icmp_id) + 32'(icmp_seq) + reply_checksum)}, 2);
        push_bytes({32'h0, icmp_id}, 2);
        push_bytes({32'h0, icmp_seq}, 2);
        for (int i = 0; i < padded; i++) begin
            exp_q.push_back((i < len) ? payload[i] : payload[len-1]);
        end
        crc = 32'hffff_ffff;
        for (int i = 8; i < exp_q.size(); i++) crc = crc_update(crc, exp_q[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++) exp_q.push_back(crc[8*i +: 8]);
    endfunction

    // ------------------------------------------------------------------
    // frame driver, restart_mid raises a second edge during the frame
    // ------------------------------------------------------------------
    task automatic run_frame(input int len, input bit restart_mid);
        int n;
        @(negedge clk);
        payload.delete();
        for (int i = 0; i < len; i++) payload.push_back(8'($urandom));
        frame_q.delete();
        req_count      = 0;
        done_count     = 0;
        pay_idx        = 0;
        payload_len    = 16'(len);
        icmp_seq       = icmp_seq + 16'd1;
        reply_checksum = payload_sum();
        start_txen     = 1'b1;
        exp_ident      = exp_ident + 16'd1;
        build_expected(exp_ident);
        if (restart_mid) begin
            n = 0;
            while (!txvld && n < FRAME_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            start_txen = 1'b0;
            repeat (5) @(negedge clk);
            start_txen = 1'b1;      // edge lands mid frame
        end
        n = 0;
        while (done_count == 0 && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (done_count == 0) begin
            errors++;
            $display("no o_tx_done within %0d cycles for a %0d byte payload",
                     FRAME_TIMEOUT, len);
        end
        start_txen = 1'b0;
        repeat (6) @(negedge clk);
        check("frame length", frame_q.size(), exp_q.size());
        for (int i = 0; i < frame_q.size() && i < exp_q.size(); i++) begin
            check($sformatf("frame byte %0d", i), {24'h0, frame_q[i]}, {24'h0, exp_q[i]});
        end
        check("payload requests", req_count, len);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_state();
        repeat (10) begin
            @(negedge clk);
            check("txvld after reset", {31'h0, txvld}, 32'h0);
            check("data_req after reset", {31'h0, data_req}, 32'h0);
            check("tx_done after reset", {31'h0, tx_done}, 32'h0);
        end
    endtask

    task automatic test_ident_counter();
        for (int f = 1; f <= 3; f++) begin
            run_frame(10, 1'b0);
            check("ip identification", {16'h0, frame_q[26], frame_q[27]}, f);
        end
    endtask

    task automatic test_long_payload();
        run_frame(40, 1'b0);
        check("long frame bytes", frame_q.size(), 94);
        check("ip total length", {16'h0, frame_q[24], frame_q[25]}, 68);
    endtask

    task automatic test_short_padding();
        run_frame(5, 1'b0);
        check("short frame bytes", frame_q.size(), 72);
        for (int i = 55; i < 68; i++) begin
            check($sformatf("pad byte %0d", i), {24'h0, frame_q[i]}, {24'h0, payload[4]});
        end
    endtask

    task automatic test_start_while_busy();
        run_frame(12, 1'b1);
        repeat (150) @(negedge clk);
        check("frames for one start", done_count, 1);
    endtask

    task automatic test_min_length();
        run_frame(18, 1'b0);
        check("min frame bytes", frame_q.size(), 72);
    endtask

    initial begin
        void'($urandom(32'h2332));
        rst_n          = 1'b0;
        start_txen     = 1'b0;
        addr.src_mac   = 48'h02_00_00_00_00_01;
        addr.src_ip    = 32'hc0a8_0001;
        addr.dst_mac   = 48'h02_00_00_00_00_77;
        addr.dst_ip    = 32'hc0a8_0042;
        icmp_id        = 16'h1234;
        icmp_seq       = 16'h0000;
        payload_len    = '0;
        reply_checksum = 32'h0;
        tx_data        = 8'h00;
        errors         = 0;
        checks         = 0;
        exp_ident      = 16'h0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_ident_counter();
        test_long_payload();
        test_short_padding();
        test_start_while_busy();
        test_min_length();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dv/icmp_tx_assertions.sv
// transmit protocol checks
`timescale 1ns/1ps

module icmp_tx_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic o_data_req,
    input logic o_txvld,
    input logic o_tx_done
);

    // done pulse comes right after the last fcs byte
    property p_done_after_vld;
        @(posedge i_clk) disable iff (!i_rst_n)
            o_tx_done |-> $past(o_txvld);
    endproperty

    // early requests fall on the last header bytes, so valid is already up
    property p_req_in_frame;
        @(posedge i_clk) disable iff (!i_rst_n)
            o_data_req |-> o_txvld;
    endproperty

    property p_vld_until_done;
        @(posedge i_clk) disable iff (!i_rst_n)
            $fell(o_txvld) |-> o_tx_done;
    endproperty

    a_done_after_vld: assert property (p_done_after_vld)
        else $error("o_tx_done without a valid byte in the cycle before");
    a_req_in_frame: assert property (p_req_in_frame)
        else $error("o_data_req outside the frame");
    a_vld_until_done: assert property (p_vld_until_done)
        else $error("o_txvld dropped before o_tx_done");

endmodule

// File: verilog/icmp_tx.sv
// icmp echo reply transmitter
`timescale 1ns/1ps

module icmp_tx #(
    parameter logic [7:0] TTL = 8'h80
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start_txen,
    input  icmp_pkg::addr_cfg_t i_addr,
    input  logic [15:0]         i_icmp_id,
    input  logic [15:0]         i_icmp_seq,
    input  icmp_pkg::len_t      i_payload_len,
    input  logic [31:0]         i_reply_checksum,   // payload word sum
    input  logic [7:0]          i_tx_data,
    output logic                o_data_req,
    output logic                o_txvld,
    output logic [7:0]          o_txdata,
    output logic                o_tx_done
);

    icmp_pkg::eth_hdr_t  s_eth;
    icmp_pkg::ip_hdr_t   s_ip;
    icmp_pkg::icmp_hdr_t s_icmp;
    icmp_pkg::len_t      s_len;
    logic                s_hdr_ready;
    logic                busy;
    logic [15:0]         ip_csum;
    logic [15:0]         icmp_csum;
    logic                ip_csum_done;
    logic                icmp_csum_done;
    logic                csum_done;
    logic                crc_en;
    logic                crc_clr;
    logic [1:0]          fcs_sel;
    logic [7:0]          fcs_byte;

    // both units start together, so this is one pulse
    assign csum_done = ip_csum_done & icmp_csum_done;

    icmp_header_build #(
        .TTL (TTL)
    ) u_header_build (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start_txen  (i_start_txen),
        .i_addr        (i_addr),
        .i_icmp_id     (i_icmp_id),
        .i_icmp_seq    (i_icmp_seq),
        .i_payload_len (i_payload_len),
        .i_busy        (busy),
        .o_eth         (s_eth),
        .o_ip          (s_ip),
        .o_icmp        (s_icmp),
        .o_len         (s_len),
        .o_hdr_ready   (s_hdr_ready)
    );

    icmp_checksum #(
        .T_HDR (icmp_pkg::ip_hdr_t)
    ) u_ip_csum (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (s_hdr_ready),
        .i_hdr       (s_ip),
        .i_extra_sum (32'h0),
        .o_sum       (ip_csum),
        .o_done      (ip_csum_done)
    );

    icmp_checksum #(
        .T_HDR (icmp_pkg::icmp_hdr_t)
    ) u_icmp_csum (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (s_hdr_ready),
        .i_hdr       (s_icmp),
        .i_extra_sum (i_reply_checksum),
        .o_sum       (icmp_csum),
        .o_done      (icmp_csum_done)
    );

    // fcs covers exactly the bytes on the output
    icmp_crc32 u_crc32 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (crc_en),
        .i_clr      (crc_clr),
        .i_byte     (o_txdata),
        .i_fcs_sel  (fcs_sel),
        .o_fcs_byte (fcs_byte)
    );

    icmp_tx_fsm u_tx_fsm (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_hdr_ready (s_hdr_ready),
        .i_csum_done (csum_done),
        .i_eth       (s_eth),
        .i_ip        (s_ip),
        .i_icmp      (s_icmp),
        .i_len       (s_len),
        .i_ip_csum   (ip_csum),
        .i_icmp_csum (icmp_csum),
        .i_tx_data   (i_tx_data),
        .i_fcs_byte  (fcs_byte),
        .o_busy      (busy),
        .o_data_req  (o_data_req),
        .o_crc_en    (crc_en),
        .o_crc_clr   (crc_clr),
        .o_fcs_sel   (fcs_sel),
        .o_txvld     (o_txvld),
        .o_txdata    (o_txdata),
        .o_tx_done   (o_tx_done)
    );

endmodule

// File: verilog/icmp_tx_fsm.sv
// frame sequencer
`timescale 1ns/1ps

module icmp_tx_fsm (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_hdr_ready,
    input  logic                i_csum_done,
    input  icmp_pkg::eth_hdr_t  i_eth,
    input  icmp_pkg::ip_hdr_t   i_ip,
    input  icmp_pkg::icmp_hdr_t i_icmp,
    input  icmp_pkg::len_t      i_len,
    input  logic [15:0]         i_ip_csum,
    input  logic [15:0]         i_icmp_csum,
    input  logic [7:0]          i_tx_data,
    input  logic [7:0]          i_fcs_byte,
    output logic                o_busy,
    output logic                o_data_req,
    output logic                o_crc_en,
    output logic                o_crc_clr,
    output logic [1:0]          o_fcs_sel,
    output logic                o_txvld,
    output logic [7:0]          o_txdata,
    output logic                o_tx_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CSUM,    // waiting on both checksums
        ST_PRE,
        ST_ETH,
        ST_HDR,     // ip + icmp header
        ST_PAY,
        ST_FCS
    } state_t;

    state_t              r_state;
    state_t              state_after;
    icmp_pkg::len_t      r_cnt;        // byte index in current field
    icmp_pkg::len_t      r_req_left;   // payload requests still owed
    icmp_pkg::len_t      pay_len;      // payload length after padding
    icmp_pkg::len_t      field_end;
    logic                r_last_fcs;
    logic                req_window;
    icmp_pkg::ip_hdr_t   ip_tx;
    icmp_pkg::icmp_hdr_t icmp_tx;
    logic [223:0]        hdr_bits;
    logic [7:0]          tx_byte;

    // ------------------------------------------------------------------
    // header bytes with checksums inserted
    // ------------------------------------------------------------------
    always_comb begin
        ip_tx           = i_ip;
        ip_tx.hdr_csum  = i_ip_csum;
        icmp_tx         = i_icmp;
        icmp_tx.csum    = i_icmp_csum;
    end

    assign hdr_bits = {ip_tx, icmp_tx};
    assign pay_len  = (i_len > icmp_pkg::MIN_PAYLOAD) ? i_len : icmp_pkg::MIN_PAYLOAD;

    // last index and successor of each sending state
    always_comb begin
        field_end   = '0;
        state_after = ST_IDLE;
        case (r_state)
            ST_PRE: begin
                field_end   = 16'd7;
                state_after = ST_ETH;
            end
            ST_ETH: begin
                field_end   = 16'd13;
                state_after = ST_HDR;
            end
            ST_HDR: begin
                field_end   = 16'd27;
                state_after = ST_PAY;
            end
            ST_PAY: begin
                field_end   = pay_len - 16'd1;
                state_after = ST_FCS;
            end
            ST_FCS: field_end = 16'd3;
            default: ;
        endcase
    end

    // requests run two bytes ahead of the payload
    assign req_window = (r_state == ST_PAY) || (r_state == ST_HDR && r_cnt >= 16'd26);
    assign o_busy     = (r_state != ST_IDLE);
    assign o_fcs_sel  = r_cnt[1:0];

    // ------------------------------------------------------------------
    // output byte mux
    // ------------------------------------------------------------------
    always_comb begin
        tx_byte = o_txdata;   // padding repeats the last byte
        case (r_state)
            ST_CSUM: tx_byte = icmp_pkg::PREAMBLE_BYTE;
            ST_PRE:  tx_byte = (r_cnt == 16'd7) ? icmp_pkg::SFD_BYTE
                                                : icmp_pkg::PREAMBLE_BYTE;
            ST_ETH:  tx_byte = i_eth[8*(13 - r_cnt[3:0]) +: 8];
            ST_HDR:  tx_byte = hdr_bits[8*(27 - r_cnt[4:0]) +: 8];
            ST_PAY: begin
                if (r_cnt < i_len) begin
                    tx_byte = i_tx_data;
                end
            end
            ST_FCS:  tx_byte = i_fcs_byte;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        o_txdata <= tx_byte;
    end

    // ------------------------------------------------------------------
    // state and strobes
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state    <= ST_IDLE;
            r_cnt      <= '0;
            r_req_left <= '0;
            r_last_fcs <= 1'b0;
            o_txvld    <= 1'b0;
            o_crc_en   <= 1'b0;
            o_data_req <= 1'b0;
            o_tx_done  <= 1'b0;
            o_crc_clr  <= 1'b0;
        end else begin
            o_txvld    <= 1'b0;
            o_crc_en   <= 1'b0;
            o_data_req <= 1'b0;
            r_last_fcs <= 1'b0;
            o_tx_done  <= r_last_fcs;   // one cycle after last fcs byte
            o_crc_clr  <= r_last_fcs;

            if (req_window && r_req_left != '0) begin
                o_data_req <= 1'b1;
                r_req_left <= r_req_left - 16'd1;
            end

            case (r_state)
                ST_IDLE: begin
                    if (i_hdr_ready) begin
                        r_state    <= ST_CSUM;
                        r_req_left <= i_len;
                    end
                end
                ST_CSUM: begin
                    if (i_csum_done) begin
                        o_txvld <= 1'b1;   // preamble byte 0 goes out now
                        r_cnt   <= 16'd1;
                        r_state <= ST_PRE;
                    end
                end
                default: begin
                    o_txvld  <= 1'b1;
                    o_crc_en <= (r_state != ST_PRE) && (r_state != ST_FCS);
                    if (r_cnt == field_end) begin
                        r_cnt      <= '0;
                        r_state    <= state_after;
                        r_last_fcs <= (r_state == ST_FCS);
                    end else begin
                        r_cnt <= r_cnt + 16'd1;
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/icmp_crc32.sv
// ethernet fcs generator
`timescale 1ns/1ps

module icmp_crc32 (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_en,
    input  logic       i_clr,
    input  logic [7:0] i_byte,
    input  logic [1:0] i_fcs_sel,
    output logic [7:0] o_fcs_byte
);

    logic [31:0] r_crc;
    logic [31:0] crc_next;

    // reflected crc-32, lsb first per byte
    function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                             input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ icmp_pkg::CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = i_en ? crc_byte(r_crc, i_byte) : r_crc;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_crc <= icmp_pkg::CRC_RESIDUE_INIT;
        end else if (i_clr) begin
            r_crc <= icmp_pkg::CRC_RESIDUE_INIT;
        end else if (i_en) begin
            r_crc <= crc_next;
        end
    end

    // byte 0 is read while the last pad byte is still going in,
    // hence the next value rather than the register
    assign o_fcs_byte = ~crc_next[8*i_fcs_sel +: 8];

endmodule

// File: verilog/icmp_header_build.sv
// frame header builder
`timescale 1ns/1ps

module icmp_header_build #(
    parameter logic [7:0] TTL = 8'h80
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start_txen,
    input  icmp_pkg::addr_cfg_t i_addr,
    input  logic [15:0]         i_icmp_id,
    input  logic [15:0]         i_icmp_seq,
    input  icmp_pkg::len_t      i_payload_len,
    input  logic                i_busy,
    output icmp_pkg::eth_hdr_t  o_eth,
    output icmp_pkg::ip_hdr_t   o_ip,
    output icmp_pkg::icmp_hdr_t o_icmp,
    output icmp_pkg::len_t      o_len,
    output logic                o_hdr_ready
);

    logic [2:0]  r_start_sync;
    logic        start_edge;
    logic        capture;
    logic [15:0] r_ident;   // last identification sent

    // ------------------------------------------------------------------
    // start synchronizer and edge trigger
    // ------------------------------------------------------------------
    assign start_edge = r_start_sync[1] & ~r_start_sync[2];
    assign capture    = start_edge & ~i_busy;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_start_sync <= '0;
            o_hdr_ready  <= 1'b0;
            r_ident      <= '0;
        end else begin
            r_start_sync <= {r_start_sync[1:0], i_start_txen};
            o_hdr_ready  <= capture;
            if (capture) begin
                r_ident <= r_ident + 16'd1;
            end
        end
    end

    // ------------------------------------------------------------------
    // header fields held for the whole frame
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (capture) begin
            o_len            <= i_payload_len;

            o_eth.dst_mac    <= i_addr.dst_mac;
            o_eth.src_mac    <= i_addr.src_mac;
            o_eth.eth_type   <= icmp_pkg::ETH_TYPE_IPV4;

            o_ip.ver_ihl     <= icmp_pkg::IP_VER_IHL;
            o_ip.tos         <= 8'h00;
            o_ip.total_len   <= i_payload_len + icmp_pkg::IP_ICMP_HDR_BYTES;
            o_ip.ident       <= r_ident + 16'd1;
            o_ip.flags_frag  <= icmp_pkg::IP_FLAGS_DF;
            o_ip.ttl         <= TTL;
            o_ip.proto       <= icmp_pkg::IP_PROTO_ICMP;
            o_ip.hdr_csum    <= 16'h0000;   // filled in on transmit
            o_ip.src_ip      <= i_addr.src_ip;
            o_ip.dst_ip      <= i_addr.dst_ip;

            o_icmp.icmp_type <= icmp_pkg::ICMP_ECHO_REPLY;
            o_icmp.code      <= 8'h00;
            o_icmp.csum      <= 16'h0000;
            o_icmp.ident     <= i_icmp_id;
            o_icmp.seq       <= i_icmp_seq;
        end
    end

endmodule

// File: verilog/icmp_checksum.sv
// internet header checksum unit
`timescale 1ns/1ps

module icmp_checksum #(
    parameter type T_HDR = icmp_pkg::ip_hdr_t
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  T_HDR        i_hdr,
    input  logic [31:0] i_extra_sum,
    output logic [15:0] o_sum,
    output logic        o_done
);

    localparam int N_WORDS = $bits(T_HDR) / 16;

    logic [$bits(T_HDR)-1:0] hdr_bits;
    logic [31:0]             word_sum;
    logic [31:0]             r_acc;
    logic [2:0]              r_stage;   // one bit per pass

    assign hdr_bits = i_hdr;

    // checksum field is zero in the header, so it drops out
    always_comb begin
        word_sum = i_extra_sum;
        for (int i = 0; i < N_WORDS; i++) begin
            word_sum = word_sum + {16'h0, hdr_bits[16*i +: 16]};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_stage <= '0;
            o_done  <= 1'b0;
        end else begin
            r_stage <= {r_stage[1:0], i_start};
            o_done  <= r_stage[2];   // four cycles after start
        end
    end

    // sum, fold, fold, complement
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            r_acc <= word_sum;
        end else if (r_stage[0] || r_stage[1]) begin
            r_acc <= {16'h0, r_acc[31:16]} + {16'h0, r_acc[15:0]};
        end
        if (r_stage[2]) begin
            o_sum <= ~r_acc[15:0];
        end
    end

endmodule

// File: verilog/icmp_pkg.sv
// icmp echo reply shared types
package icmp_pkg;

    // ------------------------------------------------------------------
    // protocol constants
    // ------------------------------------------------------------------
    localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;
    localparam logic [7:0]  IP_PROTO_ICMP     = 8'h01;
    localparam logic [7:0]  ICMP_ECHO_REPLY   = 8'h00;
    localparam logic [7:0]  IP_VER_IHL        = 8'h45;    // v4, 5 words
    localparam logic [15:0] IP_FLAGS_DF       = 16'h4000; // don't fragment
    localparam logic [15:0] IP_ICMP_HDR_BYTES = 16'd28;   // 20 ip + 8 icmp
    // 46 byte min ethernet payload less 28 header bytes
    localparam logic [15:0] MIN_PAYLOAD       = 16'd18;
    localparam logic [7:0]  PREAMBLE_BYTE     = 8'h55;
    localparam logic [7:0]  SFD_BYTE          = 8'hd5;

    localparam logic [31:0] CRC_POLY_REFL     = 32'hedb8_8320;
    localparam logic [31:0] CRC_RESIDUE_INIT  = 32'hffff_ffff;

    // ------------------------------------------------------------------
    // header and config types
    // ------------------------------------------------------------------
    typedef logic [15:0] len_t;

    typedef struct packed {
        logic [47:0] src_mac;
        logic [31:0] src_ip;
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
    } addr_cfg_t;

    // first field goes out first on the wire
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [15:0] hdr_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [7:0]  icmp_type;
        logic [7:0]  code;
        logic [15:0] csum;
        logic [15:0] ident;
        logic [15:0] seq;
    } icmp_hdr_t;

endpackage
